// ==== src/video_pkg.sv ====
// Shared widths, types and encodings for the video timing generator.
// Counters are 11 bits, so a line or frame total must stay below 2048.
// Register numbers outside reg_num_e read back as zero.

package video_pkg;

    localparam int COUNT_W        = 11;     // horizontal and vertical counter width
    localparam int INTR_W         = 4;      // number of interrupt lines
    localparam int INTR_VSYNC_BIT = 3;      // raised at end of visible frame

    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [7:0]         color_t;    // palette index
    typedef logic [15:0]        reg_data_t;

    // phases are in scan order, next phase is current plus one
    typedef enum logic [1:0] {
        STATE_PRE_SYNC  = 2'b00,
        STATE_SYNC      = 2'b01,
        STATE_POST_SYNC = 2'b10,
        STATE_VISIBLE   = 2'b11
    } sync_state_e;

    typedef enum logic [4:0] {
        REG_VID_CTRL  = 5'd0,               // border colour, sw interrupt
        REG_SCANLINE  = 5'd1,               // read only
        REG_VID_HSIZE = 5'd2,               // read only
        REG_VID_VSIZE = 5'd3                // read only
    } reg_num_e;

endpackage

// ==== src/video_timing.sv ====
// Horizontal and vertical sync phase machines with their counters.
// Each line runs front porch, sync, back porch, visible; the frame runs
// visible first, then the vertical blanking lines.
// After reset both machines start in PRE_SYNC, so the first frame is partial.
// The next-phase outputs are combinational and meant to be registered.
`timescale 1ns/1ns

module video_timing #(
    parameter int H_VISIBLE     = 640,
    parameter int H_FRONT_PORCH = 16,
    parameter int H_SYNC_PULSE  = 96,
    parameter int H_BACK_PORCH  = 48,
    parameter int V_VISIBLE     = 480,
    parameter int V_FRONT_PORCH = 10,
    parameter int V_SYNC_PULSE  = 2,
    parameter int V_BACK_PORCH  = 33
) (
    input  logic                  clk,
    input  logic                  reset_i,
    output video_pkg::count_t      h_count_o,
    output video_pkg::count_t      v_count_o,
    output video_pkg::sync_state_e h_state_o,
    output video_pkg::sync_state_e v_state_o,
    output logic                  hsync_next_o,
    output logic                  vsync_next_o,
    output logic                  de_next_o,
    output logic                  line_end_o,
    output logic                  visible_end_o
);

    import video_pkg::*;

    localparam int H_TOTAL = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH + H_VISIBLE;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    // last count of each phase
    localparam count_t H_PRE_LAST   = count_t'(H_FRONT_PORCH - 1);
    localparam count_t H_SYNC_LAST  = count_t'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
    localparam count_t H_POST_LAST  = count_t'(H_TOTAL - H_VISIBLE - 1);
    localparam count_t H_LINE_LAST  = count_t'(H_TOTAL - 1);
    localparam count_t V_VIS_LAST   = count_t'(V_VISIBLE - 1);
    localparam count_t V_PRE_LAST   = count_t'(V_VISIBLE + V_FRONT_PORCH - 1);
    localparam count_t V_SYNC_LAST  = count_t'(V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE - 1);
    localparam count_t V_FRAME_LAST = count_t'(V_TOTAL - 1);

    count_t      h_count;
    count_t      v_count;
    count_t      h_last;                    // last count of current h phase
    count_t      v_last;                    // last line of current v phase
    sync_state_e h_state;
    sync_state_e v_state;
    sync_state_e h_state_next;
    sync_state_e v_state_next;
    logic        line_end;
    logic        frame_end;

    always_comb begin
        case (h_state)
            STATE_PRE_SYNC:  h_last = H_PRE_LAST;
            STATE_SYNC:      h_last = H_SYNC_LAST;
            STATE_POST_SYNC: h_last = H_POST_LAST;
            default:         h_last = H_LINE_LAST;
        endcase
    end

    // blanking lines follow the visible area
    always_comb begin
        case (v_state)
            STATE_VISIBLE:   v_last = V_VIS_LAST;
            STATE_PRE_SYNC:  v_last = V_PRE_LAST;
            STATE_SYNC:      v_last = V_SYNC_LAST;
            default:         v_last = V_FRAME_LAST;
        endcase
    end

    always_comb h_state_next = (h_count == h_last) ? sync_state_e'(h_state + 2'd1) : h_state;
    always_comb line_end = (h_state == STATE_VISIBLE) && (h_state_next == STATE_PRE_SYNC);
    always_comb begin
        v_state_next = v_state;
        if (line_end && (v_count == v_last)) begin
            v_state_next = sync_state_e'(v_state + 2'd1);
        end
    end
    always_comb frame_end = line_end && (v_count == V_FRAME_LAST);  // wrap after the last line

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= STATE_PRE_SYNC;
            v_state <= STATE_PRE_SYNC;
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= line_end ? '0 : h_count + 1'b1;
            if (frame_end) begin
                v_count <= '0;
            end else if (line_end) begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    assign h_count_o     = h_count;
    assign v_count_o     = v_count;
    assign h_state_o     = h_state;
    assign v_state_o     = v_state;
    assign hsync_next_o  = (h_state_next == STATE_SYNC);
    assign vsync_next_o  = (v_state_next == STATE_SYNC);
    assign de_next_o     = (h_state_next == STATE_VISIBLE) && (v_state_next == STATE_VISIBLE);
    assign line_end_o    = line_end;
    assign visible_end_o = line_end && (v_state == STATE_VISIBLE)
                           && (v_state_next == STATE_PRE_SYNC);

    // sync and display-enable fall into disjoint parts of the line
    a_sync_de_excl: assert property (@(posedge clk) disable iff (reset_i)
        (!hsync_next_o || ((h_count >= H_PRE_LAST) && (h_count < H_SYNC_LAST))) &&
        (!de_next_o || ((h_count >= H_POST_LAST) && (h_count < H_LINE_LAST))));

    a_h_count_range: assert property (@(posedge clk) disable iff (reset_i)
        h_count <= H_LINE_LAST);

endmodule

// ==== src/video_regs.sv ====
// Video configuration registers with a single-cycle write strobe.
// Every write is accepted, there is no acknowledge.
// Read data is registered and follows reg_num_i one clock later.
// Only VID_CTRL is writable, the other registers are status.
`timescale 1ns/1ns

module video_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          reg_wr_i,
    input  video_pkg::reg_num_e           reg_num_i,
    input  video_pkg::reg_data_t          reg_data_i,
    output video_pkg::reg_data_t          reg_data_o,
    input  logic [video_pkg::INTR_W-1:0]  intr_status_i,
    output logic [video_pkg::INTR_W-1:0]  intr_o,
    input  logic                          visible_end_i,
    input  video_pkg::sync_state_e        h_state_i,
    input  video_pkg::sync_state_e        v_state_i,
    input  video_pkg::count_t             v_count_i,
    output video_pkg::color_t             border_color_o
);

    import video_pkg::*;

    localparam reg_data_t HSIZE_VAL = reg_data_t'(H_VISIBLE);
    localparam reg_data_t VSIZE_VAL = reg_data_t'(V_VISIBLE);
    localparam int        CTRL_PAD  = 8 - INTR_W;     // zero bits between colour and status

    color_t border_color;
    logic   ctrl_wr;

    always_comb ctrl_wr = reg_wr_i && (reg_num_i == REG_VID_CTRL);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            border_color <= 8'h08;                      // dark grey shows the core is alive
            intr_o       <= '0;
        end else begin
            intr_o <= '0;                               // pulses last one cycle
            if (ctrl_wr) begin
                border_color <= reg_data_i[15:8];
                intr_o       <= reg_data_i[INTR_W-1:0];
            end
            // frame interrupt, may coincide with a software one
            if (visible_end_i) begin
                intr_o[INTR_VSYNC_BIT] <= 1'b1;
            end
        end
    end

    // registered read path
    always_ff @(posedge clk) begin
        case (reg_num_i)
            REG_VID_CTRL: begin
                reg_data_o <= {border_color, {CTRL_PAD{1'b0}}, intr_status_i};
            end
            REG_SCANLINE: begin
                reg_data_o <= {v_state_i != STATE_VISIBLE,
                               h_state_i != STATE_VISIBLE,
                               3'b000,
                               v_count_i};
            end
            REG_VID_HSIZE: begin
                reg_data_o <= HSIZE_VAL;
            end
            REG_VID_VSIZE: begin
                reg_data_o <= VSIZE_VAL;
            end
            default: begin
                reg_data_o <= '0;                       // unassigned numbers
            end
        endcase
    end

    assign border_color_o = border_color;

    // frame interrupt only on the last pixel of the last visible line
    a_vis_end_pos: assert property (@(posedge clk) disable iff (reset_i)
        visible_end_i |-> (v_state_i == STATE_VISIBLE) && (h_state_i == STATE_VISIBLE)
                          && (v_count_i == count_t'(V_VISIBLE - 1)));

endmodule

// ==== src/video_out.sv ====
// Registered video output stage.
// Sync pins sit at 0 during reset and take their inactive level after
// the first clock out of reset.
// Colour is the border colour inside the display area and 0 in blanking.
`timescale 1ns/1ns

module video_out #(
    parameter bit H_SYNC_POLARITY = 1'b0,
    parameter bit V_SYNC_POLARITY = 1'b0
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              hsync_next_i,
    input  logic              vsync_next_i,
    input  logic              de_next_i,
    input  video_pkg::color_t border_color_i,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              dv_de_o,
    output video_pkg::color_t color_index_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
            dv_de_o       <= 1'b0;
            color_index_o <= '0;
        end else begin
            hsync_o       <= hsync_next_i ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o       <= vsync_next_i ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o       <= de_next_i;
            color_index_o <= de_next_i ? border_color_i : '0;   // black while blanking
        end
    end

endmodule

// ==== src/video_gen.sv ====
// Top level of the video timing generator.
// Default timing is 640x480, one pixel per clock.
// Outputs are registered and lag the timing counters by one clock.
// intr_o bits are single-cycle pulses, no handshake.
`timescale 1ns/1ns

module video_gen #(
    parameter int H_VISIBLE       = 640,
    parameter int H_FRONT_PORCH   = 16,
    parameter int H_SYNC_PULSE    = 96,
    parameter int H_BACK_PORCH    = 48,
    parameter int V_VISIBLE       = 480,
    parameter int V_FRONT_PORCH   = 10,
    parameter int V_SYNC_PULSE    = 2,
    parameter int V_BACK_PORCH    = 33,
    parameter bit H_SYNC_POLARITY = 1'b0,
    parameter bit V_SYNC_POLARITY = 1'b0
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          reg_wr_i,
    input  video_pkg::reg_num_e           reg_num_i,
    input  video_pkg::reg_data_t          reg_data_i,
    output video_pkg::reg_data_t          reg_data_o,
    input  logic [video_pkg::INTR_W-1:0]  intr_status_i,
    output logic [video_pkg::INTR_W-1:0]  intr_o,
    output video_pkg::color_t             color_index_o,
    output logic                          hsync_o,
    output logic                          vsync_o,
    output logic                          dv_de_o
);

    import video_pkg::*;

    count_t      v_count;
    sync_state_e h_state;
    sync_state_e v_state;
    logic        hsync_next;
    logic        vsync_next;
    logic        de_next;
    logic        visible_end;
    color_t      border_color;

    video_timing #(
        .H_VISIBLE     (H_VISIBLE),
        .H_FRONT_PORCH (H_FRONT_PORCH),
        .H_SYNC_PULSE  (H_SYNC_PULSE),
        .H_BACK_PORCH  (H_BACK_PORCH),
        .V_VISIBLE     (V_VISIBLE),
        .V_FRONT_PORCH (V_FRONT_PORCH),
        .V_SYNC_PULSE  (V_SYNC_PULSE),
        .V_BACK_PORCH  (V_BACK_PORCH)
    ) i_timing (
        .clk           (clk),
        .reset_i       (reset_i),
        .h_count_o     (),                  // only used inside the timing block
        .v_count_o     (v_count),
        .h_state_o     (h_state),
        .v_state_o     (v_state),
        .hsync_next_o  (hsync_next),
        .vsync_next_o  (vsync_next),
        .de_next_o     (de_next),
        .line_end_o    (),
        .visible_end_o (visible_end)
    );

    video_regs #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE)
    ) i_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_wr_i       (reg_wr_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .reg_data_o     (reg_data_o),
        .intr_status_i  (intr_status_i),
        .intr_o         (intr_o),
        .visible_end_i  (visible_end),
        .h_state_i      (h_state),
        .v_state_i      (v_state),
        .v_count_i      (v_count),
        .border_color_o (border_color)
    );

    video_out #(
        .H_SYNC_POLARITY (H_SYNC_POLARITY),
        .V_SYNC_POLARITY (V_SYNC_POLARITY)
    ) i_out (
        .clk            (clk),
        .reset_i        (reset_i),
        .hsync_next_i   (hsync_next),
        .vsync_next_i   (vsync_next),
        .de_next_i      (de_next),
        .border_color_i (border_color),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o),
        .color_index_o  (color_index_o)
    );

endmodule

// ==== verification/tb_clock.sv ====
// Clock and reset source for the testbench.
// Period is 8 ns; reset is high for the first three rising edges.
// Reset is released with a non-blocking update on the rising edge.
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_o <= 1'b0;                        // released on an edge, like the DUT inputs
    end

endmodule

// ==== verification/tb_video_gen.sv ====
// Testbench for video_gen with a small 24 x 11 raster, 264 cycles per frame.
// A register step table runs alongside a cycle-level timing model
// that checks sync, display-enable, colour and interrupts on every clock.
// Inputs change on the rising edge, outputs are compared before the edge or at the falling edge.
`timescale 1ns/1ns

module tb_video_gen;

    import video_pkg::*;

    localparam int H_VIS  = 16;
    localparam int H_FP   = 2;
    localparam int H_SYNC = 3;
    localparam int H_BP   = 3;
    localparam int V_VIS  = 6;
    localparam int V_FP   = 1;
    localparam int V_SYNC = 2;
    localparam int V_BP   = 2;
    localparam bit H_POL  = 1'b0;
    localparam bit V_POL  = 1'b1;

    localparam int H_TOTAL      = H_FP + H_SYNC + H_BP + H_VIS;
    localparam int V_TOTAL      = V_VIS + V_FP + V_SYNC + V_BP;
    localparam int FRAME        = H_TOTAL * V_TOTAL;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_STEPS    = 14;
    localparam int MAX_GAP      = 30;           // idle cycles before a step
    localparam int RUN_CYCLES   = RESET_CYCLES + 3 * FRAME + 2;
    localparam int TIMEOUT      = 3 * FRAME + NUM_STEPS * (MAX_GAP + 4) + 100;

    // phase codes in scan order
    localparam int PH_PRE  = 0;
    localparam int PH_SYNC = 1;
    localparam int PH_POST = 2;
    localparam int PH_VIS  = 3;

    typedef struct {
        bit          is_wr;
        logic [4:0]  num;
        logic [15:0] data;
        logic [15:0] want;                      // read value, or intr pulse for a write
        bit          use_model;                 // scanline reads take the model value
        int          gap;
    } step_t;

    logic            clk;
    logic            reset;
    logic            reg_wr;
    reg_num_e        reg_num;
    reg_data_t       reg_data;
    reg_data_t       reg_data_o;
    logic [3:0]      intr_status;
    logic [3:0]      intr_o;
    color_t          color_index_o;
    logic            hsync_o;
    logic            vsync_o;
    logic            dv_de_o;

    step_t           steps[NUM_STEPS];
    int              n_steps;
    int              cycle;
    int              n_checks;
    int              n_errors;
    int              model_vs_pulses;
    int              dut_vs_pulses;

    // model state and the outputs it expects after the last edge
    int              h_cnt;
    int              v_cnt;
    int              h_ph;
    int              v_ph;
    logic [7:0]      border;
    bit              model_valid;
    logic            exp_hsync;
    logic            exp_vsync;
    logic            exp_de;
    logic [7:0]      exp_color;
    logic [3:0]      exp_intr;
    logic            exp_vs_bit;
    logic            exp_sw_bit3;
    logic [15:0]     exp_scan;

    tb_clock #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock (
        .clk     (clk),
        .reset_o (reset)
    );

    video_gen #(
        .H_VISIBLE       (H_VIS),
        .H_FRONT_PORCH   (H_FP),
        .H_SYNC_PULSE    (H_SYNC),
        .H_BACK_PORCH    (H_BP),
        .V_VISIBLE       (V_VIS),
        .V_FRONT_PORCH   (V_FP),
        .V_SYNC_PULSE    (V_SYNC),
        .V_BACK_PORCH    (V_BP),
        .H_SYNC_POLARITY (H_POL),
        .V_SYNC_POLARITY (V_POL)
    ) i_dut (
        .clk           (clk),
        .reset_i       (reset),
        .reg_wr_i      (reg_wr),
        .reg_num_i     (reg_num),
        .reg_data_i    (reg_data),
        .reg_data_o    (reg_data_o),
        .intr_status_i (intr_status),
        .intr_o        (intr_o),
        .color_index_o (color_index_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o)
    );

    function automatic int h_phase_last(input int ph);
        case (ph)
            PH_PRE:  return H_FP - 1;
            PH_SYNC: return H_FP + H_SYNC - 1;
            PH_POST: return H_FP + H_SYNC + H_BP - 1;
            default: return H_TOTAL - 1;
        endcase
    endfunction

    function automatic int v_phase_last(input int ph);
        case (ph)
            PH_VIS:  return V_VIS - 1;
            PH_PRE:  return V_VIS + V_FP - 1;
            PH_SYNC: return V_VIS + V_FP + V_SYNC - 1;
            default: return V_TOTAL - 1;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("error: %s = %h, expected %h (cycle %0d)", name, got, want, cycle);
        end
    endtask

    task automatic add_step(input bit is_wr, input logic [4:0] num, input logic [15:0] data,
                            input logic [15:0] want, input bit use_model);
        logic [31:0] rnd;
        rnd = $urandom;
        steps[n_steps].is_wr     = is_wr;
        steps[n_steps].num       = num;
        steps[n_steps].data      = data;
        steps[n_steps].want      = want;
        steps[n_steps].use_model = use_model;
        steps[n_steps].gap       = int'(rnd % (MAX_GAP + 1));
        n_steps++;
    endtask

    task automatic build_steps();
        logic [31:0] wr_a;
        logic [31:0] wr_b;
        logic [31:0] wr_c;
        wr_a = $urandom;
        wr_b = $urandom;
        wr_c = $urandom;
        add_step(1'b1, REG_VID_CTRL, wr_a[15:0], {12'h000, wr_a[3:0]}, 1'b0);
        add_step(1'b0, REG_VID_CTRL, 16'h0000, {wr_a[15:8], 4'h0, intr_status}, 1'b0);
        add_step(1'b0, REG_VID_HSIZE, 16'h0000, 16'(H_VIS), 1'b0);
        add_step(1'b0, REG_VID_VSIZE, 16'h0000, 16'(V_VIS), 1'b0);
        add_step(1'b0, REG_SCANLINE, 16'h0000, 16'h0000, 1'b1);
        add_step(1'b0, 5'd9, 16'h0000, 16'h0000, 1'b0);        // unassigned
        add_step(1'b0, 5'd31, 16'h0000, 16'h0000, 1'b0);
        add_step(1'b1, REG_VID_HSIZE, wr_b[15:0], 16'h0000, 1'b0); // read only, no pulse
        add_step(1'b0, REG_VID_HSIZE, 16'h0000, 16'(H_VIS), 1'b0);
        add_step(1'b0, REG_VID_CTRL, 16'h0000, {wr_a[15:8], 4'h0, intr_status}, 1'b0);
        add_step(1'b1, REG_VID_CTRL, wr_c[15:0], {12'h000, wr_c[3:0]}, 1'b0);
        add_step(1'b0, REG_SCANLINE, 16'h0000, 16'h0000, 1'b1);
        add_step(1'b0, REG_SCANLINE, 16'h0000, 16'h0000, 1'b1);
        add_step(1'b0, REG_VID_CTRL, 16'h0000, {wr_c[15:8], 4'h0, intr_status}, 1'b0);
    endtask

    // drive on the rising edge, check at the falling edge after the DUT took the step
    task automatic apply_step(input step_t st);
        logic [3:0]  want_intr;
        logic [15:0] want_rd;
        repeat (st.gap + 1) @(posedge clk);
        reg_wr   <= st.is_wr;
        reg_num  <= reg_num_e'(st.num);
        reg_data <= st.data;
        @(posedge clk);
        reg_wr <= 1'b0;
        @(negedge clk);
        if (st.is_wr) begin
            want_intr = st.want[3:0] | {exp_vs_bit, 3'b000};   // frame irq may overlap
            compare_value("intr_o", 16'(intr_o), 16'(want_intr));
        end else begin
            want_rd = st.use_model ? exp_scan : st.want;
            compare_value("reg_data_o", reg_data_o, want_rd);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // timing model, checks the outputs of the last edge, then steps
    always @(posedge clk) begin : timing_model
        logic line_end;
        logic vis_end;
        logic sw_wr;
        if (model_valid) begin
            compare_value("hsync_o", 16'(hsync_o), 16'(exp_hsync));
            compare_value("vsync_o", 16'(vsync_o), 16'(exp_vsync));
            compare_value("dv_de_o", 16'(dv_de_o), 16'(exp_de));
            compare_value("color_index_o", 16'(color_index_o), 16'(exp_color));
            compare_value("intr_o", 16'(intr_o), 16'(exp_intr));
            // a software bit 3 alone is not a frame pulse
            if (intr_o[3] && (exp_vs_bit || !exp_sw_bit3)) begin
                dut_vs_pulses++;
            end
        end
        if (reset) begin
            h_cnt       = 0;
            v_cnt       = 0;
            h_ph        = PH_PRE;
            v_ph        = PH_PRE;
            border      = 8'h08;
            exp_hsync   = 1'b0;                 // pins are 0 during reset
            exp_vsync   = 1'b0;
            exp_de      = 1'b0;
            exp_color   = 8'h00;
            exp_intr    = 4'h0;
            exp_vs_bit  = 1'b0;
            exp_sw_bit3 = 1'b0;
            model_valid = 1'b1;
        end else begin
            exp_scan = {v_ph != PH_VIS, h_ph != PH_VIS, 3'b000, v_cnt[10:0]};
            line_end = (h_ph == PH_VIS) && (h_cnt == H_TOTAL - 1);
            vis_end  = line_end && (v_ph == PH_VIS) && (v_cnt == V_VIS - 1);
            if (h_cnt == h_phase_last(h_ph)) begin
                h_ph = (h_ph + 1) % 4;
            end
            h_cnt = line_end ? 0 : h_cnt + 1;
            if (line_end) begin
                if (v_cnt == v_phase_last(v_ph)) begin
                    v_ph = (v_ph + 1) % 4;
                end
                v_cnt = (v_cnt == V_TOTAL - 1) ? 0 : v_cnt + 1;
            end
            sw_wr       = reg_wr && (reg_num == REG_VID_CTRL);
            exp_hsync   = (h_ph == PH_SYNC) ? H_POL : ~H_POL;
            exp_vsync   = (v_ph == PH_SYNC) ? V_POL : ~V_POL;
            exp_de      = (h_ph == PH_VIS) && (v_ph == PH_VIS);
            exp_color   = exp_de ? border : 8'h00;     // colour before this write lands
            exp_sw_bit3 = sw_wr && reg_data[3];
            exp_intr    = (sw_wr ? reg_data[3:0] : 4'h0) | {vis_end, 3'b000};
            exp_vs_bit  = vis_end;
            if (sw_wr) begin
                border = reg_data[15:8];
            end
            if (vis_end) begin
                model_vs_pulses++;
            end
        end
    end

    initial begin : timeout_guard
        while (cycle < TIMEOUT) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0] rnd;
        rnd = $urandom(32'h82bd1d27);           // the only seeding of the run
        cycle           = 0;
        n_checks        = 0;
        n_errors        = 0;
        n_steps         = 0;
        model_vs_pulses = 0;
        dut_vs_pulses   = 0;
        model_valid     = 1'b0;
        reg_wr          = 1'b0;
        reg_num         = REG_VID_CTRL;
        reg_data        = 16'h0000;
        rnd             = $urandom;
        intr_status     = rnd[3:0];
        build_steps();
        while (reset) @(posedge clk);
        for (int i = 0; i < n_steps; i++) begin
            apply_step(steps[i]);
        end
        while (cycle < RUN_CYCLES) @(posedge clk);
        if (dut_vs_pulses != model_vs_pulses) begin
            n_errors++;
            $display("frame interrupt count is wrong: dut %0d, model %0d",
                     dut_vs_pulses, model_vs_pulses);
        end
        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
src/video_pkg.sv
src/video_timing.sv
src/video_regs.sv
src/video_out.sv
src/video_gen.sv
verification/tb_clock.sv
verification/tb_video_gen.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_video_gen
FILELIST  := compile.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# output is echoed; the exit status comes from the search for the pass message
run: compile
	./$(SIM) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)
